// File: build.f
+incdir+logic
logic/mmc_types_pkg.sv
logic/mmc_fsm_pkg.sv
logic/mmc_spi.sv
logic/crc7_gen.sv
logic/mmc_cmd_ctrl.sv
logic/mmc_cmd_host.sv
verif/mmc_card_model.sv
verif/tb_mmc_cmd_host.sv

// File: Makefile
# Verilator flow for the MMC SPI command host

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_mmc_cmd_host
RTL_TOP   ?= mmc_cmd_host
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass line shows up on stdout
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_mmc_cmd_host.sv
/*
 * testbench for the MMC SPI command host: table of init and command
 * operations run against a behavioural card
 */
`timescale 1ns/100ps
`include "mmc_defines.svh"

module tb_mmc_cmd_host;
   import mmc_types_pkg::*;

   localparam int n_rows      = 15;
   localparam int cmd_worst   = (16 + 48 + 8 * `MMC_POLL_MAX) * `MMC_BIT_LO + 200;
   localparam int cycle_limit = n_rows * cmd_worst + 100;

   logic       clk;
   logic       reset;
   logic       speed;
   logic       init_req;
   logic       cmd_req;
   cmd_index_t cmd_index;
   cmd_arg_t   cmd_arg;
   logic       busy;
   logic       resp_valid;
   logic       resp_timeout;
   spi_byte_t  resp_r1;
   logic       mmc_cs;
   logic       mmc_do;
   logic       mmc_sclk;
   logic       mmc_di;

   // card controls and what the card observed
   logic       card_clear;
   logic [3:0] card_fill;
   spi_byte_t  card_r1;
   logic       card_silent;
   cmd_frame_t card_frame;
   int         desel_clks;
   int         pre_clks;
   int         rd_bits;
   int         sclk_period;
   int         idle_cycles;

   // stimulus table, one row per operation
   logic       row_init [n_rows];
   logic       row_speed [n_rows];
   cmd_index_t row_index [n_rows];
   cmd_arg_t   row_arg [n_rows];
   int         row_fill [n_rows];
   spi_byte_t  row_r1 [n_rows];
   logic       row_silent [n_rows];

   int          cycles = 0;
   int unsigned seed_val;

   mmc_cmd_host uut (
      .clk          (clk),
      .reset        (reset),
      .speed        (speed),
      .init_req     (init_req),
      .cmd_req      (cmd_req),
      .cmd_index    (cmd_index),
      .cmd_arg      (cmd_arg),
      .busy         (busy),
      .resp_valid   (resp_valid),
      .resp_timeout (resp_timeout),
      .resp_r1      (resp_r1),
      .mmc_cs       (mmc_cs),
      .mmc_do       (mmc_do),
      .mmc_sclk     (mmc_sclk),
      .mmc_di       (mmc_di)
   );

   mmc_card_model card (
      .clk         (clk),
      .clear       (card_clear),
      .fill        (card_fill),
      .r1          (card_r1),
      .silent      (card_silent),
      .mmc_cs      (mmc_cs),
      .mmc_do      (mmc_do),
      .mmc_sclk    (mmc_sclk),
      .mmc_di      (mmc_di),
      .frame       (card_frame),
      .desel_clks  (desel_clks),
      .pre_clks    (pre_clks),
      .rd_bits     (rd_bits),
      .period      (sclk_period),
      .idle_cycles (idle_cycles)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display(">>> FAIL");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic report_error(string msg);
      $display("Error [%0t] %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic check_frame(cmd_frame_t got, cmd_frame_t exp, string what);
      if (got !== exp)
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic check_byte(spi_byte_t got, spi_byte_t exp, string what);
      if (got !== exp)
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp)
         report_error($sformatf("%s: got %b, expected %b", what, got, exp));
   endtask

   task automatic check_count(int got, int exp, string what);
      if (got != exp)
         report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
   endtask

   // x^7 + x^3 + 1 from zero, header MSB first
   function automatic crc7_t crc7_of(logic [39:0] header);
      crc7_t c;
      logic  fb;
      int    k;
      c = '0;
      for (k = 39; k >= 0; k--)
      begin
         fb = header[k] ^ c[6];
         c  = c << 1;
         if (fb)
            c = c ^ 7'h09;
      end
      return c;
   endfunction

   function automatic cmd_frame_t build_frame(cmd_index_t idx, cmd_arg_t arg);
      return {2'b01, idx, arg, crc7_of({2'b01, idx, arg}), 1'b1};
   endfunction

   task automatic add_row(int r, logic is_init, logic spd, cmd_index_t idx,
                          cmd_arg_t arg, int fill, spi_byte_t r1, logic silent);
      row_init[r]   = is_init;
      row_speed[r]  = spd;
      row_index[r]  = idx;
      row_arg[r]    = arg;
      row_fill[r]   = fill;
      row_r1[r]     = r1;
      row_silent[r] = silent;
   endtask

   task automatic build_table();
      cmd_arg_t pair_arg;
      int       f;
      add_row(0, 1'b1, 1'b0, '0, '0, 0, '0, 1'b0);
      add_row(1, 1'b0, 1'b0, 6'd0, 32'd0, 0, 8'h01, 1'b0);
      // every filler count the poll limit allows
      for (f = 0; f < 8; f++)
         add_row(2 + f, 1'b0, 1'b1, 6'($urandom), $urandom, f,
                 8'($urandom) & 8'h7f, 1'b0);
      add_row(10, 1'b0, 1'b1, 6'd55, $urandom, 0, 8'h00, 1'b1);
      pair_arg = $urandom;
      add_row(11, 1'b0, 1'b0, 6'd17, pair_arg, 2, 8'h00, 1'b0);
      add_row(12, 1'b0, 1'b1, 6'd17, pair_arg, 2, 8'h00, 1'b0);
      add_row(13, 1'b0, 1'b0, 6'd58, $urandom, 0, 8'h00, 1'b1);
      add_row(14, 1'b1, 1'b1, '0, '0, 0, '0, 1'b0);
   endtask

   task automatic run_init(int i);
      int bit_len;
      bit_len = row_speed[i] ? `MMC_BIT_HI : `MMC_BIT_LO;
      @(posedge clk);
      speed      <= row_speed[i];
      card_clear <= 1'b1;
      @(posedge clk);
      card_clear <= 1'b0;
      init_req   <= 1'b1;
      @(posedge clk);
      init_req <= 1'b0;
      while (busy !== 1'b1)
         @(posedge clk);
      while (busy !== 1'b0)
      begin
         check_flag(resp_valid, 1'b0, "resp_valid during init");
         @(posedge clk);
      end
      check_flag(resp_valid, 1'b0, "resp_valid at end of init");
      check_count(desel_clks, `MMC_INIT_BITS, "init clocks with cs and data high");
      check_count(sclk_period, bit_len, "card clock period");
      if (idle_cycles < `MMC_QUIET_BITS * bit_len)
         report_error($sformatf("quiet period of %0d cycles is under %0d bit times",
                                idle_cycles, `MMC_QUIET_BITS));
   endtask

   task automatic run_cmd(int i);
      cmd_frame_t exp_frame;
      spi_byte_t  exp_r1;
      logic       exp_to;
      int         exp_bytes;
      int         bit_len;
      exp_frame = build_frame(row_index[i], row_arg[i]);
      exp_r1    = row_silent[i] ? 8'hff : row_r1[i];
      exp_to    = row_silent[i];
      exp_bytes = row_silent[i] ? `MMC_POLL_MAX : row_fill[i] + 1;
      bit_len   = row_speed[i] ? `MMC_BIT_HI : `MMC_BIT_LO;
      @(posedge clk);
      speed       <= row_speed[i];
      card_fill   <= 4'(row_fill[i]);
      card_r1     <= row_r1[i];
      card_silent <= row_silent[i];
      card_clear  <= 1'b1;
      @(posedge clk);
      card_clear <= 1'b0;
      cmd_index  <= row_index[i];
      cmd_arg    <= row_arg[i];
      cmd_req    <= 1'b1;
      @(posedge clk);
      cmd_req <= 1'b0;
      while (resp_valid !== 1'b1)
         @(posedge clk);
      check_flag(busy, 1'b0, "busy alongside resp_valid");
      check_byte(resp_r1, exp_r1, "resp_r1");
      check_flag(resp_timeout, exp_to, "resp_timeout");
      check_frame(card_frame, exp_frame, "captured frame");
      check_count(pre_clks, 8, "deselected clocks before cs fell");
      check_count(rd_bits, 8 * exp_bytes, "bits read after the frame");
      check_count(sclk_period, bit_len, "card clock period");
   endtask

   initial
   begin
      int i;
      reset       = 1'b1;
      speed       = 1'b0;
      init_req    = 1'b0;
      cmd_req     = 1'b0;
      cmd_index   = '0;
      cmd_arg     = '0;
      card_clear  = 1'b1;
      card_fill   = '0;
      card_r1     = '0;
      card_silent = 1'b0;
      seed_val    = $urandom(32'h6b8c);
      build_table();
      // CMD0 ends in the well known byte 0x95
      check_byte({crc7_of(40'h4000000000), 1'b1}, 8'h95, "reference CRC7 of CMD0");
      repeat (16) @(posedge clk);
      reset      <= 1'b0;
      card_clear <= 1'b0;
      repeat (2) @(posedge clk);
      for (i = 0; i < n_rows; i++)
      begin
         if (row_init[i])
            run_init(i);
         else
            run_cmd(i);
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: verif/mmc_card_model.sv
/*
 * behavioural SPI card: captures command frames, counts card clocks,
 * answers with filler bytes and an R1
 */
`timescale 1ns/100ps

module mmc_card_model (
   input  logic                      clk,
   input  logic                      clear,
   input  logic [3:0]                fill,
   input  mmc_types_pkg::spi_byte_t  r1,
   input  logic                      silent,
   input  logic                      mmc_cs,
   input  logic                      mmc_do,
   input  logic                      mmc_sclk,
   output logic                      mmc_di,
   output mmc_types_pkg::cmd_frame_t frame,
   output int                        desel_clks,
   output int                        pre_clks,
   output int                        rd_bits,
   output int                        period,
   output int                        idle_cycles
);
   import mmc_types_pkg::*;

   logic sclk_q;
   logic cs_q;
   logic rise;
   logic fall;
   int   frame_bits;
   int   resp_pos;

   // edges seen one system clock late, all at the same lag
   assign rise = mmc_sclk && !sclk_q;
   assign fall = !mmc_sclk && sclk_q;

   // filler bytes of ones, then R1, then ones again
   function automatic logic resp_bit(int pos, logic [3:0] n_fill, spi_byte_t r,
                                     logic quiet);
      if (quiet || pos / 8 != int'(n_fill))
         return 1'b1;
      return r[7 - pos % 8];
   endfunction

   always @(posedge clk)
   begin
      sclk_q <= mmc_sclk;
      cs_q   <= mmc_cs;
      if (clear)
      begin
         mmc_di      <= 1'b1;
         frame       <= '0;
         desel_clks  <= 0;
         pre_clks    <= 0;
         rd_bits     <= 0;
         frame_bits  <= 0;
         resp_pos    <= 0;
         idle_cycles <= 0;
      end
      else
      begin
         if (rise)
         begin
            period      <= idle_cycles;
            idle_cycles <= 1;
            if (mmc_cs && mmc_do)
               desel_clks <= desel_clks + 1;
            else if (!mmc_cs && frame_bits < 48)
            begin
               frame      <= {frame[46:0], mmc_do};
               frame_bits <= frame_bits + 1;
            end
            else if (!mmc_cs)
               rd_bits <= rd_bits + 1;
         end
         else
            idle_cycles <= idle_cycles + 1;
         // card output moves on the falling edge once the frame is in
         if (fall && !mmc_cs && frame_bits == 48)
         begin
            mmc_di   <= resp_bit(resp_pos, fill, r1, silent);
            resp_pos <= resp_pos + 1;
         end
         if (cs_q && !mmc_cs)
            pre_clks <= desel_clks;
         if (mmc_cs && !cs_q)
            mmc_di <= 1'b1;
      end
   end

endmodule

// File: logic/mmc_cmd_host.sv
/*
 * MMC SPI command host top: sequencer, CRC7 generator and bit engine
 */
`timescale 1ns/100ps

module mmc_cmd_host (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      speed,
   input  logic                      init_req,
   input  logic                      cmd_req,
   input  mmc_types_pkg::cmd_index_t cmd_index,
   input  mmc_types_pkg::cmd_arg_t   cmd_arg,
   output logic                      busy,
   output logic                      resp_valid,
   output logic                      resp_timeout,
   output mmc_types_pkg::spi_byte_t  resp_r1,
   output logic                      mmc_cs,
   output logic                      mmc_do,
   output logic                      mmc_sclk,
   input  logic                      mmc_di
);
   import mmc_types_pkg::*;

   logic        crc_start;
   logic [39:0] crc_header;
   crc7_t       crc;
   logic        crc_valid;
   logic        spi_init;
   logic        spi_send;
   logic        spi_rd;
   logic        spi_stop;
   logic        spi_done;
   cmd_frame_t  spi_cmd;
   spi_byte_t   spi_data;

   mmc_cmd_ctrl ctrl (
      .clk          (clk),
      .reset        (reset),
      .init_req     (init_req),
      .cmd_req      (cmd_req),
      .cmd_index    (cmd_index),
      .cmd_arg      (cmd_arg),
      .crc          (crc),
      .crc_valid    (crc_valid),
      .spi_data     (spi_data),
      .spi_done     (spi_done),
      .crc_start    (crc_start),
      .spi_init     (spi_init),
      .spi_send     (spi_send),
      .spi_rd       (spi_rd),
      .spi_stop     (spi_stop),
      .crc_header   (crc_header),
      .spi_cmd      (spi_cmd),
      .busy         (busy),
      .resp_valid   (resp_valid),
      .resp_timeout (resp_timeout),
      .resp_r1      (resp_r1)
   );

   crc7_gen crc7 (
      .clk        (clk),
      .reset      (reset),
      .crc_start  (crc_start),
      .crc_header (crc_header),
      .crc        (crc),
      .crc_valid  (crc_valid)
   );

   mmc_spi spi (
      .clk      (clk),
      .reset    (reset),
      .speed    (speed),
      .init     (spi_init),
      .send     (spi_send),
      .rd       (spi_rd),
      .stop     (spi_stop),
      .cmd      (spi_cmd),
      .data_out (spi_data),
      .done     (spi_done),
      .mmc_cs   (mmc_cs),
      .mmc_do   (mmc_do),
      .mmc_sclk (mmc_sclk),
      .mmc_di   (mmc_di)
   );

endmodule

// File: logic/mmc_cmd_ctrl.sv
/*
 * MMC command sequencer: joins CRC and engine results, frames the command,
 * polls for R1 and reports
 */
`timescale 1ns/100ps
`include "mmc_defines.svh"

module mmc_cmd_ctrl (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      init_req,
   input  logic                      cmd_req,
   input  mmc_types_pkg::cmd_index_t cmd_index,
   input  mmc_types_pkg::cmd_arg_t   cmd_arg,
   input  mmc_types_pkg::crc7_t      crc,
   input  logic                      crc_valid,
   input  mmc_types_pkg::spi_byte_t  spi_data,
   input  logic                      spi_done,
   output logic                      crc_start,
   output logic                      spi_init,
   output logic                      spi_send,
   output logic                      spi_rd,
   output logic                      spi_stop,
   output logic [39:0]               crc_header,
   output mmc_types_pkg::cmd_frame_t spi_cmd,
   output logic                      busy,
   output logic                      resp_valid,
   output logic                      resp_timeout,
   output mmc_types_pkg::spi_byte_t  resp_r1
);
   import mmc_fsm_pkg::*;

   localparam int poll_w = $clog2(`MMC_POLL_MAX + 1);

   ctrl_state_t       state;
   logic [39:0]       hdr;
   logic [poll_w-1:0] poll_cnt;
   logic              engine_ready;
   logic              accept_cmd;
   logic              prep_go;
   logic              byte_in;
   logic              poll_end;

   // done is ignored in the cycle of our own strobe
   assign engine_ready = spi_done && !(spi_init || spi_send || spi_rd || spi_stop);

   assign accept_cmd = state == ctrl_idle && cmd_req && !init_req;
   assign prep_go    = state == ctrl_prep && engine_ready && crc_valid;
   assign byte_in    = state == ctrl_poll_wait && engine_ready;
   assign poll_end   = !spi_data[7] || poll_cnt == poll_w'(`MMC_POLL_MAX - 1);

   assign busy       = state != ctrl_idle;
   assign crc_header = hdr;

   always_ff @(posedge clk)
   begin
      if (accept_cmd)
         hdr <= {2'b01, cmd_index, cmd_arg};
      if (prep_go)
         spi_cmd <= {hdr, crc, 1'b1};
      if (byte_in && poll_end)
      begin
         resp_r1      <= spi_data;
         resp_timeout <= spi_data[7];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= ctrl_idle;
         crc_start  <= 1'b0;
         spi_init   <= 1'b0;
         spi_send   <= 1'b0;
         spi_rd     <= 1'b0;
         spi_stop   <= 1'b0;
         resp_valid <= 1'b0;
         poll_cnt   <= '0;
      end
      else
      begin
         crc_start  <= 1'b0;
         spi_init   <= 1'b0;
         spi_send   <= 1'b0;
         spi_rd     <= 1'b0;
         spi_stop   <= 1'b0;
         resp_valid <= 1'b0;
         case (state)
            ctrl_idle:
            begin
               if (init_req)
               begin
                  spi_init <= 1'b1;
                  state    <= ctrl_init_run;
               end
               else if (cmd_req)
               begin
                  // 8 deselected clocks run alongside the CRC
                  crc_start <= 1'b1;
                  spi_stop  <= 1'b1;
                  poll_cnt  <= '0;
                  state     <= ctrl_prep;
               end
            end
            ctrl_init_run:
               if (engine_ready)
                  state <= ctrl_idle;
            ctrl_prep:
               if (prep_go)
               begin
                  spi_send <= 1'b1;
                  state    <= ctrl_send;
               end
            ctrl_send:
               if (engine_ready)
                  state <= ctrl_poll;
            ctrl_poll:
            begin
               spi_rd <= 1'b1;
               state  <= ctrl_poll_wait;
            end
            ctrl_poll_wait:
               if (byte_in)
               begin
                  if (poll_end)
                  begin
                     spi_stop <= 1'b1;
                     state    <= ctrl_tail;
                  end
                  else
                  begin
                     poll_cnt <= poll_cnt + 1'b1;
                     state    <= ctrl_poll;
                  end
               end
            ctrl_tail:
               if (engine_ready)
                  state <= ctrl_finish;
            ctrl_finish:
            begin
               resp_valid <= 1'b1;
               state      <= ctrl_idle;
            end
            default:
               state <= ctrl_idle;
         endcase
      end
   end

   a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
      resp_valid |=> !resp_valid);

endmodule

// File: logic/crc7_gen.sv
/*
 * serial CRC7 over a 40-bit command header, one bit per clock
 */
`timescale 1ns/100ps

module crc7_gen (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 crc_start,
   input  logic [39:0]          crc_header,
   output mmc_types_pkg::crc7_t crc,
   output logic                 crc_valid
);
   import mmc_types_pkg::*;

   logic [38:0] hdr;
   logic [5:0]  cnt;
   logic        running;

   function automatic crc7_t crc7_step(crc7_t c, logic b);
      logic fb;
      fb = c[6] ^ b;
      return {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
   endfunction

   // first bit goes in on the start cycle
   always_ff @(posedge clk)
   begin
      if (crc_start)
      begin
         crc <= crc7_step('0, crc_header[39]);
         hdr <= crc_header[38:0];
      end
      else if (running)
      begin
         crc <= crc7_step(crc, hdr[38]);
         hdr <= {hdr[37:0], 1'b0};
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         running   <= 1'b0;
         crc_valid <= 1'b0;
         cnt       <= '0;
      end
      else if (crc_start)
      begin
         running   <= 1'b1;
         crc_valid <= 1'b0;
         cnt       <= 6'd1;
      end
      else if (running)
      begin
         cnt <= cnt + 6'd1;
         if (cnt == 6'd39)
         begin
            running   <= 1'b0;
            crc_valid <= 1'b1;
         end
      end
   end

endmodule

// File: logic/mmc_spi.sv
/*
 * MMC SPI bit engine: times card clock edges, shifts 48-bit commands out
 * and bytes in, and runs the power-up and deselect sequences
 */
`timescale 1ns/100ps
`include "mmc_defines.svh"

module mmc_spi (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     speed,
   input  logic                     init,
   input  logic                     send,
   input  logic                     rd,
   input  logic                     stop,
   input  mmc_types_pkg::cmd_frame_t cmd,
   output mmc_types_pkg::spi_byte_t  data_out,
   output logic                     done,
   output logic                     mmc_cs,
   output logic                     mmc_do,
   output logic                     mmc_sclk,
   input  logic                     mmc_di
);
   import mmc_types_pkg::*;
   import mmc_fsm_pkg::*;

   localparam int bit_lo = `MMC_BIT_LO;
   localparam int bit_hi = `MMC_BIT_HI;

   spi_state_t state;
   spi_state_t state_nx;
   cmd_frame_t s_cmd;

   logic       speed_hi;
   logic [7:0] bit_time;
   logic [7:0] bit_max;
   logic [7:0] bit_half;
   logic       bit_mid;
   logic       bit_end;
   logic [6:0] bit_cnt;
   logic [6:0] bit_last;
   logic       counting;
   logic       clocked;
   logic       last_bit;

   always_ff @(posedge clk)
   begin
      if (reset)
         speed_hi <= 1'b0;
      else
         speed_hi <= speed;
   end

   assign bit_max  = speed_hi ? 8'(bit_hi - 1) : 8'(bit_lo - 1);
   assign bit_half = speed_hi ? 8'(bit_hi / 2) : 8'(bit_lo / 2);

   // >= so a speed change mid-bit cannot overrun the timer
   assign bit_mid = bit_time == bit_half;
   assign bit_end = bit_time >= bit_max;

   assign counting = state inside {spi_cmd_shift, spi_rd_shift, spi_init_clk,
                                   spi_init_quiet, spi_stop_clk};
   assign clocked  = counting && state != spi_init_quiet;

   always_comb
   begin
      case (state)
         spi_cmd_shift:  bit_last = 7'd47;
         spi_init_clk:   bit_last = 7'(`MMC_INIT_BITS - 1);
         spi_init_quiet: bit_last = 7'(`MMC_INIT_BITS + `MMC_QUIET_BITS - 1);
         default:        bit_last = 7'd7;
      endcase
   end

   assign last_bit = counting && bit_end && bit_cnt == bit_last;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bit_time <= '0;
         bit_cnt  <= '0;
      end
      else if (!counting)
      begin
         bit_time <= '0;
         bit_cnt  <= '0;
      end
      else if (bit_end)
      begin
         bit_time <= '0;
         bit_cnt  <= bit_cnt + 7'd1;
      end
      else
         bit_time <= bit_time + 8'd1;
   end

   always_comb
   begin
      state_nx = state;
      case (state)
         spi_idle:
         begin
            if (init)
               state_nx = spi_init_clk;
            else if (send)
               state_nx = spi_cmd_load;
            else if (rd)
               state_nx = spi_rd_shift;
            else if (stop)
               state_nx = spi_stop_wait;
         end
         spi_cmd_load:   state_nx = spi_cmd_shift;
         spi_init_clk:   state_nx = last_bit ? spi_init_quiet : state;
         spi_stop_wait:  state_nx = spi_stop_clk;
         spi_done0:      state_nx = spi_done1;
         spi_done1:      state_nx = spi_done2;
         spi_done2:      state_nx = spi_idle;
         default:        state_nx = last_bit ? spi_done0 : state;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= spi_idle;
      else
         state <= state_nx;
   end

   assign done = state == spi_idle;

   // fill with ones so the line idles high after the end bit
   always_ff @(posedge clk)
   begin
      if (state == spi_idle && send)
         s_cmd <= cmd;
      else if (state == spi_cmd_shift && bit_end)
         s_cmd <= {s_cmd[46:0], 1'b1};
   end

   always_ff @(posedge clk)
   begin
      if (state == spi_rd_shift && bit_mid)
         data_out <= {data_out[6:0], mmc_di};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mmc_cs   <= 1'b1;
         mmc_do   <= 1'b1;
         mmc_sclk <= 1'b0;
      end
      else
      begin
         // high from mid-bit to end of bit
         mmc_sclk <= clocked && (bit_mid || (mmc_sclk && !bit_end));
         case (state)
            spi_init_clk, spi_init_quiet, spi_stop_wait:
            begin
               mmc_cs <= 1'b1;
               mmc_do <= 1'b1;
            end
            spi_cmd_load:
            begin
               mmc_cs <= 1'b0;
               mmc_do <= s_cmd[47];
            end
            spi_cmd_shift:
            begin
               if (bit_end)
                  mmc_do <= s_cmd[46];
            end
            spi_done0:
               mmc_do <= 1'b1;
            default:
               ;
         endcase
      end
   end

   // controller only strobes an idle engine
   a_strobe_idle: assert property (@(posedge clk) disable iff (reset)
      (init || send || rd || stop) |-> done);

endmodule

// File: logic/mmc_fsm_pkg.sv
/*
 * MMC command host state encodings for the SPI bit engine and the command sequencer
 */
package mmc_fsm_pkg;

   typedef enum logic [3:0] {
      spi_idle,
      spi_cmd_load,
      spi_cmd_shift,
      spi_rd_shift,
      spi_init_clk,
      spi_init_quiet,
      spi_stop_wait,
      spi_stop_clk,
      spi_done0,
      spi_done1,
      spi_done2
   } spi_state_t;

   typedef enum logic [2:0] {
      ctrl_idle,
      ctrl_init_run,
      ctrl_prep,
      ctrl_send,
      ctrl_poll,
      ctrl_poll_wait,
      ctrl_tail,
      ctrl_finish
   } ctrl_state_t;

endpackage

// File: logic/mmc_types_pkg.sv
/*
 * MMC command host data types: command fields, wire frame, CRC7 and bytes
 */
package mmc_types_pkg;

   // command fields
   typedef logic [5:0] cmd_index_t;
   typedef logic [31:0] cmd_arg_t;

   // start, transmission, index, argument, crc7, end
   typedef logic [47:0] cmd_frame_t;

   // x^7 + x^3 + 1, seeded with zero
   typedef logic [6:0] crc7_t;

   // received byte or R1
   typedef logic [7:0] spi_byte_t;

endpackage

// File: logic/mmc_defines.svh
/*
 * MMC SPI host timing constants: clock rates, bit widths, power-up and poll limits
 */
`ifndef MMC_DEFINES_SVH
`define MMC_DEFINES_SVH

`define MMC_FREQ       50000000
`define MMC_RATE_LO    400000
`define MMC_RATE_HI    12500000

// system clocks per card bit
`define MMC_BIT_LO     (`MMC_FREQ / `MMC_RATE_LO)
`define MMC_BIT_HI     (`MMC_FREQ / `MMC_RATE_HI)

`define MMC_POLL_MAX   8
`define MMC_INIT_BITS  80
`define MMC_QUIET_BITS 20

`endif
